// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_v_decode
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
v_pkg.sv
v_ctrl.sv
v_rf_ctrl.sv
v_rf.sv
v_csr.sv
v_decode.sv
tb_v_decode.sv

// File: tb_v_decode.sv
/*
 * Testbench for the vector decode stage
 * Random instruction source, execute-unit responder and in-order model
 */
`default_nettype none

module tb_v_decode;

    localparam int VLEN      = 64;
    localparam int NUM_INSTR = 300;
    localparam int TIMEOUT   = NUM_INSTR * 8 + 200;

    logic                          clk         = 1'b0;
    logic                          arst_n      = 1'b0;
    logic                          clear_pipe  = 1'b0;
    logic                          instr_valid = 1'b0;
    logic [v_pkg::INSTR_W-1:0]     instr       = '0;
    logic [v_pkg::XLEN-1:0]        scalar_data = '0;
    logic                          exe_ready   = 1'b0;
    logic [VLEN-1:0]               alu_result  = '0;
    logic [v_pkg::VREG_ADDR_W-1:0] syn_addr    = '0;
    logic                          instr_ready;
    logic                          exe_valid;
    logic [VLEN-1:0]               exe_srca;
    logic [VLEN-1:0]               exe_srcb;
    logic [v_pkg::XLEN-1:0]        exe_scalar;
    logic                          is_vector_scalar_exe;
    logic                          is_i2v_exe;
    logic                          is_add_exe;
    logic                          is_sub_exe;
    logic                          is_and_exe;
    logic                          is_or_exe;
    logic                          is_xor_exe;
    logic                          is_setvl_exe;
    logic [v_pkg::VL_W-1:0]        vl;
    logic [v_pkg::SEW_W-1:0]       vtype_sew;
    logic [VLEN-1:0]               syn_data;
    logic [7:0]                    exe_flags;

    integer                    seed     = 32'h906e_0d23;
    int                        cycles   = 0;
    int                        issued   = 0;
    int                        csr_wait = 0;
    logic                      running  = 1'b0;
    logic                      hold_chk = 1'b0;
    logic                      clr_chk  = 1'b0;
    logic                      acc_chk  = 1'b0;
    logic [VLEN-1:0]           model_regs [16];
    logic [v_pkg::VL_W-1:0]    model_vl  = '0;
    logic [v_pkg::SEW_W-1:0]   model_sew = '0;
    logic [v_pkg::INSTR_W-1:0] q_instr [$];
    logic [v_pkg::XLEN-1:0]    q_scalar [$];
    logic [VLEN-1:0]           snap_a;
    logic [VLEN-1:0]           snap_b;
    logic [v_pkg::XLEN-1:0]    snap_s;
    logic [7:0]                snap_flags;

    v_decode #(
        .VLEN (VLEN)
    ) i_v_decode (.*);

    // Flag order {vx, i2v, add, sub, and, or, xor, setvl}
    assign exe_flags = {is_vector_scalar_exe, is_i2v_exe, is_add_exe, is_sub_exe,
                        is_and_exe, is_or_exe, is_xor_exe, is_setvl_exe};

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input logic [VLEN-1:0] got, input logic [VLEN-1:0] exp,
                         input string name);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [3:0] pick_reg();
        logic [7:0] r;
        r = 8'($random(seed));
        // Mostly v0..v3 so that hazards and forwarding show up
        return (r[7:6] == 2'b11) ? r[3:0] : {2'b00, r[1:0]};
    endfunction

    function automatic logic [v_pkg::INSTR_W-1:0] new_instr();
        logic [7:0] r;
        logic [3:0] opc;
        r   = 8'($random(seed));
        opc = 4'(r % 8'd9);
        return {opc, pick_reg(), pick_reg(), pick_reg()};
    endfunction

    function automatic logic [7:0] exp_flags(input logic [3:0] opc);
        case (opc)
            v_pkg::OP_VADD_VV: return 8'b0010_0000;
            v_pkg::OP_VSUB_VV: return 8'b0001_0000;
            v_pkg::OP_VAND_VV: return 8'b0000_1000;
            v_pkg::OP_VOR_VV:  return 8'b0000_0100;
            v_pkg::OP_VXOR_VV: return 8'b0000_0010;
            v_pkg::OP_VADD_VX: return 8'b1010_0000;
            v_pkg::OP_VMV_VX:  return 8'b0100_0000;
            v_pkg::OP_VSETVL:  return 8'b0000_0001;
            default:           return 8'b0000_0000;
        endcase
    endfunction

    // Ready when the exe slot is empty or firing and no RAW on its vector write
    function automatic logic exp_ready(input logic [v_pkg::INSTR_W-1:0] id_ins);
        logic [v_pkg::INSTR_W-1:0] ex_ins;
        logic [3:0]                ex_opc;
        logic [3:0]                id_opc;
        logic                      raw;
        raw    = 1'b0;
        id_opc = id_ins[v_pkg::OPC_LSB +: 4];
        if (exe_valid && q_instr.size() != 0) begin
            ex_ins = q_instr[0];
            ex_opc = ex_ins[v_pkg::OPC_LSB +: 4];
            raw    = (ex_opc >= v_pkg::OP_VADD_VV) && (ex_opc <= v_pkg::OP_VMV_VX) &&
                     (id_opc >= v_pkg::OP_VADD_VV) && (id_opc <= v_pkg::OP_VADD_VX) &&
                     ((ex_ins[v_pkg::VD_LSB +: 4] == id_ins[v_pkg::VS1_LSB +: 4]) ||
                      (ex_ins[v_pkg::VD_LSB +: 4] == id_ins[v_pkg::VS2_LSB +: 4]));
        end
        // A clear empties the slot, so nothing may enter it on that edge
        return !clear_pipe && (!exe_valid || exe_ready) && !raw;
    endfunction

    // Reference result from model operands, keyed by opcode
    function automatic logic [VLEN-1:0] model_op(input logic [3:0] opc,
                                                 input logic [VLEN-1:0] a,
                                                 input logic [VLEN-1:0] b,
                                                 input logic [v_pkg::XLEN-1:0] s);
        logic [VLEN-1:0] rep;
        rep = {(VLEN / v_pkg::XLEN){s}};
        case (opc)
            v_pkg::OP_VADD_VV: return a + b;
            v_pkg::OP_VSUB_VV: return a - b;
            v_pkg::OP_VAND_VV: return a & b;
            v_pkg::OP_VOR_VV:  return a | b;
            v_pkg::OP_VXOR_VV: return a ^ b;
            v_pkg::OP_VADD_VX: return a + rep;
            v_pkg::OP_VMV_VX:  return rep;
            default:           return '0;
        endcase
    endfunction

    // Execute unit, works from the exe outputs and flags only
    function automatic logic [VLEN-1:0] respond();
        logic [VLEN-1:0] rep;
        rep = {(VLEN / v_pkg::XLEN){exe_scalar}};
        if (is_setvl_exe) return VLEN'(exe_scalar[v_pkg::VL_W+v_pkg::SEW_W-1:0]);
        if (is_i2v_exe) return rep;
        if (is_vector_scalar_exe) return exe_srca + rep;
        if (is_add_exe) return exe_srca + exe_srcb;
        if (is_sub_exe) return exe_srca - exe_srcb;
        if (is_and_exe) return exe_srca & exe_srcb;
        if (is_or_exe) return exe_srca | exe_srcb;
        if (is_xor_exe) return exe_srca ^ exe_srcb;
        return '0;
    endfunction

    task automatic compare_regs();
        for (int i = 0; i < 16; i++) begin
            syn_addr <= 4'(i);
            @(posedge clk);
            check(syn_data, model_regs[i], $sformatf("syn_data[v%0d]", i));
        end
    endtask

    // Checks and model update from the values just before the edge
    task automatic observe_edge();
        logic [v_pkg::INSTR_W-1:0] ins;
        logic [v_pkg::XLEN-1:0]    s;
        logic [3:0]                opc;
        logic [VLEN-1:0]           a;
        logic [VLEN-1:0]           b;
        int                        vlmax;
        if (hold_chk) begin
            check(VLEN'(exe_valid), VLEN'(1'b1), "exe_valid");
            check(exe_srca, snap_a, "exe_srca");
            check(exe_srcb, snap_b, "exe_srcb");
            check(VLEN'(exe_scalar), VLEN'(snap_s), "exe_scalar");
            check(VLEN'(exe_flags), VLEN'(snap_flags), "exe flags");
        end
        if (clr_chk) begin
            check(VLEN'(exe_valid), '0, "exe_valid after clear_pipe");
        end
        if (acc_chk) begin
            check(VLEN'(exe_valid), VLEN'(1'b1), "exe_valid after accept");
        end
        if (csr_wait == 1) begin
            check(VLEN'(vl), VLEN'(model_vl), "vl");
            check(VLEN'(vtype_sew), VLEN'(model_sew), "vtype_sew");
        end
        if (csr_wait != 0) begin
            csr_wait--;
        end
        if (instr_valid) begin
            check(VLEN'(instr_ready), VLEN'(exp_ready(instr)), "instr_ready");
        end
        hold_chk   = exe_valid && !exe_ready && !clear_pipe;
        clr_chk    = clear_pipe;
        acc_chk    = instr_valid && instr_ready;
        snap_a     = exe_srca;
        snap_b     = exe_srcb;
        snap_s     = exe_scalar;
        snap_flags = exe_flags;

        // Transfer or drop by clear_pipe both retire the oldest entry
        if (exe_valid && (exe_ready || clear_pipe)) begin
            if (q_instr.size() == 0) begin
                $display("The exe slot is valid but no accepted instruction is left");
                stop_run();
            end
            ins = q_instr.pop_front();
            s   = q_scalar.pop_front();
        end
        if (exe_valid && exe_ready) begin
            opc = ins[v_pkg::OPC_LSB +: 4];
            a   = model_regs[ins[v_pkg::VS1_LSB +: 4]];
            b   = model_regs[ins[v_pkg::VS2_LSB +: 4]];
            check(VLEN'(exe_scalar), VLEN'(s), "exe_scalar");
            check(VLEN'(exe_flags), VLEN'(exp_flags(opc)), "exe flags");
            if (opc >= v_pkg::OP_VADD_VV && opc <= v_pkg::OP_VADD_VX) begin
                check(exe_srca, a, "exe_srca");
                check(exe_srcb, b, "exe_srcb");
            end
            if (opc >= v_pkg::OP_VADD_VV && opc <= v_pkg::OP_VMV_VX) begin
                model_regs[ins[v_pkg::VD_LSB +: 4]] = model_op(opc, a, b, s);
            end
            if (opc == v_pkg::OP_VSETVL) begin
                vlmax     = (VLEN / 8) << s[9:8];
                model_sew = s[9:8];
                model_vl  = (int'(s[7:0]) < vlmax) ? s[7:0] : 8'(vlmax);
                csr_wait  = 2;
            end
        end
        if (instr_valid && instr_ready) begin
            q_instr.push_back(instr);
            q_scalar.push_back(scalar_data);
            issued++;
        end
    endtask

    task automatic drive_edge();
        // Answer only once the exe slot is known to stay put
        if (hold_chk && ($random(seed) & 1) == 1) begin
            exe_ready  <= 1'b1;
            alu_result <= respond();
        end else begin
            exe_ready <= 1'b0;
        end
        clear_pipe <= (($random(seed) & 31) == 0);
        if (!(instr_valid && !instr_ready)) begin
            if (issued < NUM_INSTR && ($random(seed) & 3) != 0) begin
                instr_valid <= 1'b1;
                instr       <= new_instr();
                scalar_data <= $random(seed);
            end else begin
                instr_valid <= 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            stop_run();
        end
    end

    always @(posedge clk) begin
        if (running) begin
            observe_edge();
            drive_edge();
        end
    end

    initial begin
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check(VLEN'(exe_valid), '0, "exe_valid after reset");
        check(VLEN'(vl), '0, "vl after reset");
        check(VLEN'(vtype_sew), '0, "vtype_sew after reset");
        compare_regs();

        running <= 1'b1;
        @(posedge clk);
        while (issued < NUM_INSTR || instr_valid || exe_valid) begin
            @(posedge clk);
        end
        // Let the last writeback and CSR update land
        repeat (3) @(posedge clk);
        check(VLEN'(vl), VLEN'(model_vl), "vl at end");
        check(VLEN'(vtype_sew), VLEN'(model_sew), "vtype_sew at end");
        compare_regs();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: v_csr.sv
/*
 * vl and vtype control registers
 * vl writes are clamped to VLMAX of the written SEW
 */
`default_nettype none

module v_csr #(
    parameter int VLEN = 64
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                wr_en,
    input  logic [v_pkg::VL_W+v_pkg::SEW_W-1:0] wr_data,
    output logic [v_pkg::VL_W-1:0]              vl,
    output logic [v_pkg::SEW_W-1:0]             vtype_sew
);

    logic [v_pkg::VL_W-1:0]  req_vl;
    logic [v_pkg::SEW_W-1:0] req_sew;
    logic [31:0]             vlmax;
    logic [v_pkg::VL_W-1:0]  vl_clamped;

    assign req_vl  = wr_data[v_pkg::VL_W-1:0];
    assign req_sew = wr_data[v_pkg::VL_W +: v_pkg::SEW_W];

    // VLEN/8 scaled by 2^SEW
    assign vlmax      = 32'(VLEN / 8) << req_sew;
    assign vl_clamped = (32'(req_vl) < vlmax) ? req_vl : vlmax[v_pkg::VL_W-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vl        <= '0;
            vtype_sew <= '0;
        end else if (wr_en) begin
            vl        <= vl_clamped;
            vtype_sew <= req_sew;
        end
    end

endmodule

`default_nettype wire

// File: v_ctrl.sv
/*
 * Vector decode control unit
 * Field extraction, opcode decode and exe-stage operation flags
 */
`default_nettype none

module v_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [v_pkg::INSTR_W-1:0]     instr,
    input  logic                          id_fire,
    input  logic                          flush,
    output logic [v_pkg::VREG_ADDR_W-1:0] vs1_id,
    output logic [v_pkg::VREG_ADDR_W-1:0] vs2_id,
    output logic [v_pkg::VREG_ADDR_W-1:0] vd_id,
    output logic                          wr_vreg_id,
    output logic                          wr_csr_id,
    output logic                          hazard_id,
    output logic                          is_vector_scalar_exe,
    output logic                          is_i2v_exe,
    output logic                          is_add_exe,
    output logic                          is_sub_exe,
    output logic                          is_and_exe,
    output logic                          is_or_exe,
    output logic                          is_xor_exe,
    output logic                          is_setvl_exe
);

    // Operand source class
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_VV,
        SRC_VX,
        SRC_X
    } src_class_e;

    localparam int F_VX    = 7;
    localparam int F_I2V   = 6;
    localparam int F_ADD   = 5;
    localparam int F_SUB   = 4;
    localparam int F_AND   = 3;
    localparam int F_OR    = 2;
    localparam int F_XOR   = 1;
    localparam int F_SETVL = 0;

    v_pkg::v_opcode_e opcode;
    src_class_e       src_class;
    logic [7:0]       flags_id;
    logic [7:0]       flags_exe;

    assign opcode = v_pkg::v_opcode_e'(instr[v_pkg::OPC_LSB +: v_pkg::OPC_W]);
    assign vd_id  = instr[v_pkg::VD_LSB +: v_pkg::VREG_ADDR_W];
    assign vs1_id = instr[v_pkg::VS1_LSB +: v_pkg::VREG_ADDR_W];
    assign vs2_id = instr[v_pkg::VS2_LSB +: v_pkg::VREG_ADDR_W];

    always_comb begin
        flags_id  = '0;
        src_class = SRC_NONE;
        case (opcode)
            v_pkg::OP_VADD_VV: begin
                src_class       = SRC_VV;
                flags_id[F_ADD] = 1'b1;
            end
            v_pkg::OP_VSUB_VV: begin
                src_class       = SRC_VV;
                flags_id[F_SUB] = 1'b1;
            end
            v_pkg::OP_VAND_VV: begin
                src_class       = SRC_VV;
                flags_id[F_AND] = 1'b1;
            end
            v_pkg::OP_VOR_VV: begin
                src_class      = SRC_VV;
                flags_id[F_OR] = 1'b1;
            end
            v_pkg::OP_VXOR_VV: begin
                src_class       = SRC_VV;
                flags_id[F_XOR] = 1'b1;
            end
            v_pkg::OP_VADD_VX: begin
                src_class       = SRC_VX;
                flags_id[F_VX]  = 1'b1;
                flags_id[F_ADD] = 1'b1;
            end
            v_pkg::OP_VMV_VX: begin
                src_class       = SRC_X;
                flags_id[F_I2V] = 1'b1;
            end
            v_pkg::OP_VSETVL: begin
                src_class         = SRC_X;
                flags_id[F_SETVL] = 1'b1;
            end
            default: ;
        endcase
    end

    assign hazard_id  = (src_class == SRC_VV) || (src_class == SRC_VX);
    assign wr_csr_id  = flags_id[F_SETVL];
    assign wr_vreg_id = (src_class != SRC_NONE) && !wr_csr_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flags_exe <= '0;
        end else if (flush) begin
            flags_exe <= '0;
        end else if (id_fire) begin
            flags_exe <= flags_id;
        end
    end

    assign is_vector_scalar_exe = flags_exe[F_VX];
    assign is_i2v_exe           = flags_exe[F_I2V];
    assign is_add_exe           = flags_exe[F_ADD];
    assign is_sub_exe           = flags_exe[F_SUB];
    assign is_and_exe           = flags_exe[F_AND];
    assign is_or_exe            = flags_exe[F_OR];
    assign is_xor_exe           = flags_exe[F_XOR];
    assign is_setvl_exe         = flags_exe[F_SETVL];

endmodule

`default_nettype wire

// File: v_decode.sv
/*
 * Vector coprocessor decode stage top level
 * Control unit, register file controller, register file and CSRs
 */
`default_nettype none

module v_decode #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          clear_pipe,
    input  logic                          instr_valid,
    input  logic [v_pkg::INSTR_W-1:0]     instr,
    input  logic [v_pkg::XLEN-1:0]        scalar_data,
    input  logic                          exe_ready,
    input  logic [VLEN-1:0]               alu_result,
    input  logic [v_pkg::VREG_ADDR_W-1:0] syn_addr,
    output logic                          instr_ready,
    output logic                          exe_valid,
    output logic [VLEN-1:0]               exe_srca,
    output logic [VLEN-1:0]               exe_srcb,
    output logic [v_pkg::XLEN-1:0]        exe_scalar,
    output logic                          is_vector_scalar_exe,
    output logic                          is_i2v_exe,
    output logic                          is_add_exe,
    output logic                          is_sub_exe,
    output logic                          is_and_exe,
    output logic                          is_or_exe,
    output logic                          is_xor_exe,
    output logic                          is_setvl_exe,
    output logic [v_pkg::VL_W-1:0]        vl,
    output logic [v_pkg::SEW_W-1:0]       vtype_sew,
    output logic [VLEN-1:0]               syn_data
);

    logic [v_pkg::VREG_ADDR_W-1:0]       vs1_id;
    logic [v_pkg::VREG_ADDR_W-1:0]       vs2_id;
    logic [v_pkg::VREG_ADDR_W-1:0]       vd_id;
    logic                                wr_vreg_id;
    logic                                wr_csr_id;
    logic                                hazard_id;
    logic                                id_fire;
    logic                                flush;
    logic [VLEN-1:0]                     rf_srca_id;
    logic [VLEN-1:0]                     rf_srcb_id;
    logic                                wb_wr_en;
    logic [v_pkg::VREG_ADDR_W-1:0]       wb_addr;
    logic [VLEN-1:0]                     wb_data;
    logic                                csr_wr_en;
    logic [v_pkg::VL_W+v_pkg::SEW_W-1:0] csr_data;

    v_ctrl i_v_ctrl (
        .clk                  (clk),
        .arst_n               (arst_n),
        .instr                (instr),
        .id_fire              (id_fire),
        .flush                (flush),
        .vs1_id               (vs1_id),
        .vs2_id               (vs2_id),
        .vd_id                (vd_id),
        .wr_vreg_id           (wr_vreg_id),
        .wr_csr_id            (wr_csr_id),
        .hazard_id            (hazard_id),
        .is_vector_scalar_exe (is_vector_scalar_exe),
        .is_i2v_exe           (is_i2v_exe),
        .is_add_exe           (is_add_exe),
        .is_sub_exe           (is_sub_exe),
        .is_and_exe           (is_and_exe),
        .is_or_exe            (is_or_exe),
        .is_xor_exe           (is_xor_exe),
        .is_setvl_exe         (is_setvl_exe)
    );

    v_rf_ctrl #(
        .VLEN (VLEN)
    ) i_v_rf_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_pipe  (clear_pipe),
        .instr_valid (instr_valid),
        .exe_ready   (exe_ready),
        .vs1_id      (vs1_id),
        .vs2_id      (vs2_id),
        .vd_id       (vd_id),
        .wr_vreg_id  (wr_vreg_id),
        .wr_csr_id   (wr_csr_id),
        .hazard_id   (hazard_id),
        .rf_srca_id  (rf_srca_id),
        .rf_srcb_id  (rf_srcb_id),
        .scalar_data (scalar_data),
        .alu_result  (alu_result),
        .instr_ready (instr_ready),
        .id_fire     (id_fire),
        .flush       (flush),
        .exe_valid   (exe_valid),
        .exe_srca    (exe_srca),
        .exe_srcb    (exe_srcb),
        .exe_scalar  (exe_scalar),
        .wb_wr_en    (wb_wr_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .csr_wr_en   (csr_wr_en),
        .csr_data    (csr_data)
    );

    v_rf #(
        .VLEN (VLEN)
    ) i_v_rf (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_addr_a (vs1_id),
        .rd_addr_b (vs2_id),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .wr_en     (wb_wr_en),
        .syn_addr  (syn_addr),
        .rd_data_a (rf_srca_id),
        .rd_data_b (rf_srcb_id),
        .syn_data  (syn_data)
    );

    v_csr #(
        .VLEN (VLEN)
    ) i_v_csr (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (csr_wr_en),
        .wr_data   (csr_data),
        .vl        (vl),
        .vtype_sew (vtype_sew)
    );

endmodule

`default_nettype wire

// File: v_pkg.sv
/*
 * Shared definitions for the vector decode stage
 * Opcode enum, instruction field positions, widths and register count
 */
`default_nettype none

package v_pkg;

    localparam int INSTR_W     = 16;
    localparam int VREG_ADDR_W = 4;
    localparam int VREG_NUM    = 2 ** VREG_ADDR_W;
    localparam int XLEN        = 32;
    localparam int SEW_W       = 2;
    localparam int VL_W        = 8;

    // Instruction layout {opcode, vd, vs1, vs2}
    localparam int OPC_W   = 4;
    localparam int OPC_LSB = 12;
    localparam int VD_LSB  = 8;
    localparam int VS1_LSB = 4;
    localparam int VS2_LSB = 0;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP     = 4'h0,
        OP_VADD_VV = 4'h1,
        OP_VSUB_VV = 4'h2,
        OP_VAND_VV = 4'h3,
        OP_VOR_VV  = 4'h4,
        OP_VXOR_VV = 4'h5,
        OP_VADD_VX = 4'h6,
        OP_VMV_VX  = 4'h7,
        OP_VSETVL  = 4'h8
    } v_opcode_e;

endpackage

`default_nettype wire

// File: v_rf.sv
/*
 * Vector register file
 * Two asynchronous read ports, one write port and a debug read port
 */
`default_nettype none

module v_rf #(
    parameter int VLEN = 64
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [v_pkg::VREG_ADDR_W-1:0] rd_addr_a,
    input  logic [v_pkg::VREG_ADDR_W-1:0] rd_addr_b,
    input  logic [v_pkg::VREG_ADDR_W-1:0] wr_addr,
    input  logic [VLEN-1:0]               wr_data,
    input  logic                          wr_en,
    input  logic [v_pkg::VREG_ADDR_W-1:0] syn_addr,
    output logic [VLEN-1:0]               rd_data_a,
    output logic [VLEN-1:0]               rd_data_b,
    output logic [VLEN-1:0]               syn_data
);

    logic [VLEN-1:0] regs [v_pkg::VREG_NUM];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < v_pkg::VREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];
    // Observation only
    assign syn_data  = regs[syn_addr];

endmodule

`default_nettype wire

// File: v_rf_ctrl.sv
/*
 * Register file pipeline controller
 * Exe and wb registers, wb forwarding, hazard stall and both handshakes
 */
`default_nettype none

module v_rf_ctrl #(
    parameter int VLEN = 64
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                clear_pipe,
    input  logic                                instr_valid,
    input  logic                                exe_ready,
    input  logic [v_pkg::VREG_ADDR_W-1:0]       vs1_id,
    input  logic [v_pkg::VREG_ADDR_W-1:0]       vs2_id,
    input  logic [v_pkg::VREG_ADDR_W-1:0]       vd_id,
    input  logic                                wr_vreg_id,
    input  logic                                wr_csr_id,
    input  logic                                hazard_id,
    input  logic [VLEN-1:0]                     rf_srca_id,
    input  logic [VLEN-1:0]                     rf_srcb_id,
    input  logic [v_pkg::XLEN-1:0]              scalar_data,
    input  logic [VLEN-1:0]                     alu_result,
    output logic                                instr_ready,
    output logic                                id_fire,
    output logic                                flush,
    output logic                                exe_valid,
    output logic [VLEN-1:0]                     exe_srca,
    output logic [VLEN-1:0]                     exe_srcb,
    output logic [v_pkg::XLEN-1:0]              exe_scalar,
    output logic                                wb_wr_en,
    output logic [v_pkg::VREG_ADDR_W-1:0]       wb_addr,
    output logic [VLEN-1:0]                     wb_data,
    output logic                                csr_wr_en,
    output logic [v_pkg::VL_W+v_pkg::SEW_W-1:0] csr_data
);

    logic                          exe_fire;
    logic                          stall;
    logic                          exe_wr_vreg;
    logic                          exe_wr_csr;
    logic [v_pkg::VREG_ADDR_W-1:0] exe_vd;
    logic [VLEN-1:0]               fwd_a;
    logic [VLEN-1:0]               fwd_b;

    assign exe_fire = exe_valid && exe_ready;

    // RAW on an exe-stage vector write, not yet forwardable
    assign stall = hazard_id && exe_valid && exe_wr_vreg &&
                   ((vs1_id == exe_vd) || (vs2_id == exe_vd));

    assign instr_ready = !clear_pipe && !stall && (!exe_valid || exe_ready);
    assign id_fire     = instr_valid && instr_ready;
    // Drop exe flags on clear or when the slot drains
    assign flush       = clear_pipe || (exe_fire && !id_fire);

    assign fwd_a = (wb_wr_en && (wb_addr == vs1_id)) ? wb_data : rf_srca_id;
    assign fwd_b = (wb_wr_en && (wb_addr == vs2_id)) ? wb_data : rf_srcb_id;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe_valid   <= 1'b0;
            exe_wr_vreg <= 1'b0;
            exe_wr_csr  <= 1'b0;
        end else if (clear_pipe) begin
            exe_valid <= 1'b0;
        end else if (id_fire) begin
            exe_valid   <= 1'b1;
            exe_wr_vreg <= wr_vreg_id;
            exe_wr_csr  <= wr_csr_id;
        end else if (exe_fire) begin
            exe_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (id_fire) begin
            exe_srca   <= fwd_a;
            exe_srcb   <= fwd_b;
            exe_scalar <= scalar_data;
            exe_vd     <= vd_id;
        end
    end

    // Writeback stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_wr_en  <= 1'b0;
            csr_wr_en <= 1'b0;
        end else begin
            wb_wr_en  <= exe_fire && exe_wr_vreg;
            csr_wr_en <= exe_fire && exe_wr_csr;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_fire) begin
            wb_addr  <= exe_vd;
            wb_data  <= alu_result;
            csr_data <= alu_result[v_pkg::VL_W+v_pkg::SEW_W-1:0];
        end
    end

    a_exe_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        exe_valid && !exe_ready && !clear_pipe |=>
            exe_valid && $stable(exe_srca) && $stable(exe_srcb) && $stable(exe_scalar)
    ) else $error("exe outputs changed under back-pressure");

    a_wb_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wb_wr_en && csr_wr_en)
    ) else $error("vector and CSR writeback both enabled");

endmodule

`default_nettype wire
